//--- common/game_defines.svh
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// cells per side of the square playfield.
`define GRID_N 5

// player start cell.
// bottom row, centre lane.
`define PLAYER_START_X 2
`define PLAYER_START_Y 4

// nonzero lane LFSR seed.
`define LFSR_SEED 4'b0001

// score counter width.
`define SCORE_W 8

`endif

//--- common/game_pkg.sv
`default_nettype none

`include "game_defines.svh"

package game_pkg;

	// one grid coordinate.
	typedef logic [$clog2(`GRID_N)-1:0] cell_t;

	// row 0 is the top row, x 0 the left column.
	typedef struct packed {
		cell_t x;
		cell_t y;
	} pos_t;

	// cell (x, y) sits at bit y * GRID_N + x.
	typedef logic [`GRID_N*`GRID_N-1:0] board_t;

	// at most one falling block per row.
	typedef struct packed {
		logic  valid;
		cell_t lane;
	} block_row_t;

	// indexed by row.
	typedef block_row_t [`GRID_N-1:0] field_t;

	typedef struct packed {
		logic left;
		logic right;
		logic up;
		logic down;
	} move_cmd_t;

	typedef logic [`SCORE_W-1:0] score_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		JUDGE,
		OVER
	} game_state_t;

endpackage

`default_nettype wire

//--- rtl/lane_picker.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module lane_picker
(
	input  logic            clock,
	input  logic            reset,
	input  logic            advance,
	output game_pkg::cell_t lane
);

	import game_pkg::*;

	logic [3:0] lfsr;
	logic [3:0] prev_raw;
	logic [3:0] raw;
	logic [3:0] prev_up;
	logic [3:0] prev_dn;
	cell_t      raw_cell;
	cell_t      last_lane;

	// x^4 + x^3 + 1 runs through all fifteen nonzero states.
	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			lfsr <= `LFSR_SEED;
			prev_raw <= 4'd15;
		end
		else if (advance)
		begin
			lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
			prev_raw <= raw;
		end
	end

	assign raw = lfsr % 4'(`GRID_N);
	assign raw_cell = cell_t'(raw);
	assign last_lane = cell_t'(`GRID_N - 1);

	// 4-bit neighbours.
	// after reset 15 wraps up to 0.
	assign prev_up = prev_raw + 4'd1;
	assign prev_dn = prev_raw - 4'd1;

	// a lane next to the last raw pick is pushed one further away.
	always_comb
	begin
		if (raw == prev_up)
		begin
			if (raw_cell == last_lane)
				lane = '0;
			else
				lane = raw_cell + 1'b1;
		end
		else if (raw == prev_dn)
		begin
			if (raw_cell == '0)
				lane = last_lane;
			else
				lane = raw_cell - 1'b1;
		end
		else
		begin
			lane = raw_cell;
		end
	end

endmodule

`default_nettype wire

//--- block_field/block_field.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module block_field
(
	input  logic             clock,
	input  logic             reset,
	input  logic             advance,
	input  logic             clear,
	output game_pkg::field_t field
);

	import game_pkg::*;

	cell_t      lane;
	block_row_t spawn;

	lane_picker i_lane_picker
	(
		.clock   (clock),
		.reset   (reset),
		.advance (advance),
		.lane    (lane)
	);

	// new block for the top row.
	assign spawn.valid = 1'b1;
	assign spawn.lane = lane;

	// rows move down one step.
	// the bottom block drops off the field.
	always_ff @(posedge clock)
	begin
		if (!reset || clear)
		begin
			for (int r = 0; r < `GRID_N; r++)
			begin
				field[r].valid <= 1'b0;
			end
		end
		else if (advance)
		begin
			field <= {field[`GRID_N-2:0], spawn};
		end
	end

endmodule

`default_nettype wire

//--- rtl/player_mover.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module player_mover
(
	input  logic                clock,
	input  logic                reset,
	input  logic                advance,
	input  logic                clear,
	input  game_pkg::move_cmd_t move,
	output game_pkg::pos_t      player
);

	import game_pkg::*;

	pos_t  start_pos;
	pos_t  next_pos;
	cell_t edge_max;

	assign start_pos.x = cell_t'(`PLAYER_START_X);
	assign start_pos.y = cell_t'(`PLAYER_START_Y);
	assign edge_max = cell_t'(`GRID_N - 1);

	// right wins over left and down over up.
	// a move into an edge holds that coordinate.
	always_comb
	begin
		next_pos = player;
		if (move.right)
		begin
			if (player.x != edge_max)
				next_pos.x = player.x + 1'b1;
		end
		else if (move.left)
		begin
			if (player.x != '0)
				next_pos.x = player.x - 1'b1;
		end

		if (move.down)
		begin
			if (player.y != edge_max)
				next_pos.y = player.y + 1'b1;
		end
		else if (move.up)
		begin
			if (player.y != '0)
				next_pos.y = player.y - 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!reset || clear)
			player <= start_pos;
		else if (advance)
			player <= next_pos;
	end

endmodule

`default_nettype wire

//--- rtl/collision_judge.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module collision_judge
(
	input  game_pkg::field_t field,
	input  game_pkg::pos_t   player,
	output game_pkg::board_t board,
	output logic             hit
);

	localparam int CELLS = `GRID_N * `GRID_N;
	localparam int IDX_W = $clog2(CELLS);

	logic [IDX_W-1:0] player_idx;

	// each valid row lights one cell.
	always_comb
	begin
		board = '0;
		for (int r = 0; r < `GRID_N; r++)
		begin
			if (field[r].valid)
				board[r * `GRID_N + int'(field[r].lane)] = 1'b1;
		end
	end

	// player cell in board bit order.
	assign player_idx = IDX_W'(player.y) * IDX_W'(`GRID_N) + IDX_W'(player.x);

	assign hit = board[player_idx];

endmodule

`default_nettype wire

//--- rtl/game_control.sv
`timescale 1ns/1ps
`default_nettype none

module game_control
(
	input  logic             clock,
	input  logic             reset,
	input  logic             start,
	input  logic             step,
	input  logic             hit,
	output logic             advance,
	output logic             clear,
	output logic             ready,
	output logic             game_over,
	output game_pkg::score_t score
);

	import game_pkg::*;

	game_state_t state;
	game_state_t next_state;
	logic        waiting;

	assign ready = (state == RUN);
	assign game_over = (state == OVER);
	assign waiting = (state == IDLE) || (state == OVER);

	// steps outside RUN are dropped.
	assign advance = step && ready;

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
			begin
				if (clear)
					next_state = RUN;
			end
			RUN:
			begin
				if (advance)
					next_state = JUDGE;
			end
			// field and player already hold the stepped values here.
			JUDGE:
			begin
				if (hit)
					next_state = OVER;
				else
					next_state = RUN;
			end
			OVER:
			begin
				if (clear)
					next_state = RUN;
			end
			default:
			begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!reset)
		begin
			state <= IDLE;
			clear <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// single pulse even if start is held.
			clear <= start && waiting && !clear;
		end
	end

	// saturating count of steps survived.
	always_ff @(posedge clock)
	begin
		if (!reset || clear)
			score <= '0;
		else if (state == JUDGE && !hit && score != '1)
			score <= score + 1'b1;
	end

endmodule

`default_nettype wire

//--- rtl/block_game.sv
`timescale 1ns/1ps
`default_nettype none

module block_game
(
	input  logic                clock,
	input  logic                reset,
	input  logic                start,
	input  logic                step,
	input  game_pkg::move_cmd_t move,
	output logic                ready,
	output logic                game_over,
	output game_pkg::score_t    score,
	output game_pkg::board_t    board,
	output game_pkg::pos_t      player
);

	import game_pkg::*;

	logic   advance;
	logic   clear;
	logic   hit;
	field_t field;

	game_control i_game_control
	(
		.clock     (clock),
		.reset     (reset),
		.start     (start),
		.step      (step),
		.hit       (hit),
		.advance   (advance),
		.clear     (clear),
		.ready     (ready),
		.game_over (game_over),
		.score     (score)
	);

	// blocks and player update side by side.
	block_field i_block_field
	(
		.clock   (clock),
		.reset   (reset),
		.advance (advance),
		.clear   (clear),
		.field   (field)
	);

	player_mover i_player_mover
	(
		.clock   (clock),
		.reset   (reset),
		.advance (advance),
		.clear   (clear),
		.move    (move),
		.player  (player)
	);

	collision_judge i_collision_judge
	(
		.field  (field),
		.player (player),
		.board  (board),
		.hit    (hit)
	);

endmodule

`default_nettype wire

//--- bench/block_game_chk.sv
`timescale 1ns/1ps
`default_nettype none

module block_game_chk
(
	input logic             clock,
	input logic             reset,
	input logic             ready,
	input logic             game_over,
	input logic             advance,
	input game_pkg::score_t score
);

	ready_not_over: assert property (@(posedge clock) disable iff (!reset)
		!(ready && game_over))
	else $error("ready and game_over are high together");

	// an accepted step is followed by one judge cycle with ready low.
	advance_when_ready: assert property (@(posedge clock) disable iff (!reset)
		advance |=> ($past(ready) && !ready))
	else $error("advance pulsed while ready was low or ready stayed high after it");

	// score frozen once the game has ended.
	score_held_over: assert property (@(posedge clock) disable iff (!reset)
		(game_over && $past(game_over)) |-> $stable(score))
	else $error("score changed during game over");

	over_low_after_reset: assert property (@(posedge clock)
		$rose(reset) |-> !game_over)
	else $error("game_over high in the first cycle after reset");

endmodule

bind block_game block_game_chk i_block_game_chk
(
	.clock     (clock),
	.reset     (reset),
	.ready     (ready),
	.game_over (game_over),
	.advance   (advance),
	.score     (score)
);

`default_nettype wire

//--- bench/block_game_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "game_defines.svh"

module block_game_tb;

	import game_pkg::*;

	localparam int CLK_HALF = 5;
	localparam int STEP_BUDGET = 100;
	localparam int CYCLES_PER_STEP = 4;
	localparam int TIMEOUT_NS = STEP_BUDGET * CYCLES_PER_STEP * 2 * CLK_HALF * 5;

	logic      clock;
	logic      reset;
	logic      start;
	logic      step;
	move_cmd_t move;
	logic      ready;
	logic      game_over;
	score_t    score;
	board_t    board;
	pos_t      player;

	integer seed;
	int     errors;

	// reference model state.
	int m_lfsr;
	int m_prev;
	bit m_valid [`GRID_N];
	int m_lane [`GRID_N];
	int m_px;
	int m_py;
	int m_score;
	bit m_over;
	bit m_ready;

	block_game i_block_game
	(
		.clock     (clock),
		.reset     (reset),
		.start     (start),
		.step      (step),
		.move      (move),
		.ready     (ready),
		.game_over (game_over),
		.score     (score),
		.board     (board),
		.player    (player)
	);

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#(CLK_HALF);
			clock = ~clock;
		end
	end

	task automatic stop_with_failure(input string why);
		errors++;
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("** Error at %0t ns: %s expected %0h, actual %0h",
				$time, name, expected, actual);
			stop_with_failure("output mismatch against the reference model");
		end
	endtask

	function automatic move_cmd_t make_move(input logic left, input logic right,
		input logic up, input logic down);
		move_cmd_t m;
		m.left = left;
		m.right = right;
		m.up = up;
		m.down = down;
		return m;
	endfunction

	// a raw pick next to the previous raw pick moves one lane further.
	function automatic int model_lane();
		int raw;
		raw = m_lfsr % `GRID_N;
		if (raw == (m_prev + 1) % 16)
			return (raw + 1) % `GRID_N;
		if (raw == (m_prev + 15) % 16)
			return (raw == 0) ? `GRID_N - 1 : raw - 1;
		return raw;
	endfunction

	function automatic board_t model_board();
		board_t b;
		b = '0;
		for (int r = 0; r < `GRID_N; r++)
		begin
			if (m_valid[r])
				b[r * `GRID_N + m_lane[r]] = 1'b1;
		end
		return b;
	endfunction

	task automatic model_clear();
		for (int r = 0; r < `GRID_N; r++)
			m_valid[r] = 1'b0;
		m_px = `PLAYER_START_X;
		m_py = `PLAYER_START_Y;
		m_score = 0;
		m_over = 1'b0;
	endtask

	task automatic model_step(input move_cmd_t cmd);
		int lane;
		lane = model_lane();
		m_prev = m_lfsr % `GRID_N;
		m_lfsr = ((m_lfsr << 1) & 14) | (((m_lfsr >> 3) ^ (m_lfsr >> 2)) & 1);
		for (int r = `GRID_N - 1; r > 0; r--)
		begin
			m_valid[r] = m_valid[r - 1];
			m_lane[r] = m_lane[r - 1];
		end
		m_valid[0] = 1'b1;
		m_lane[0] = lane;
		if (cmd.right && m_px < `GRID_N - 1)
			m_px++;
		else if (!cmd.right && cmd.left && m_px > 0)
			m_px--;
		if (cmd.down && m_py < `GRID_N - 1)
			m_py++;
		else if (!cmd.down && cmd.up && m_py > 0)
			m_py--;
		if (m_valid[m_py] && m_lane[m_py] == m_px)
			m_over = 1'b1;
		else if (m_score < 255)
			m_score++;
		m_ready = !m_over;
	endtask

	task automatic check_outputs();
		check_value("game_over", m_over, game_over);
		check_value("ready", m_ready, ready);
		check_value("score", m_score, score);
		check_value("board", model_board(), board);
		check_value("player.x", m_px, player.x);
		check_value("player.y", m_py, player.y);
	endtask

	// ready rises exactly one cycle after start is sampled.
	task automatic start_game();
		start = 1'b1;
		@(posedge clock);
		#1;
		start = 1'b0;
		check_value("ready", 0, ready);
		@(posedge clock);
		#1;
		model_clear();
		m_ready = 1'b1;
		check_outputs();
	endtask

	task automatic do_step(input move_cmd_t cmd);
		int cycles;
		check_value("ready", 1, ready);
		step = 1'b1;
		move = cmd;
		@(posedge clock);
		#1;
		step = 1'b0;
		move = '0;
		model_step(cmd);
		cycles = 0;
		while (!ready && !game_over)
		begin
			if (cycles == 8)
				stop_with_failure("DUT gave neither ready nor game_over after a step");
			@(posedge clock);
			#1;
			cycles++;
		end
		check_outputs();
	endtask

	task automatic play_step(input move_cmd_t cmd);
		if (m_over)
			start_game();
		do_step(cmd);
	endtask

	// moves one way until a step starts at the edge it pushes against.
	task automatic press_to_edge(input move_cmd_t cmd);
		int  n;
		bit  at_edge;
		bit  pressed;
		n = 0;
		pressed = 1'b0;
		while (!pressed)
		begin
			if (n == 20)
				stop_with_failure("player never pressed against the grid edge");
			if (m_over)
				start_game();
			at_edge = (cmd.left && m_px == 0) || (cmd.right && m_px == `GRID_N - 1)
				|| (cmd.up && m_py == 0) || (cmd.down && m_py == `GRID_N - 1);
			do_step(cmd);
			pressed = at_edge;
			n++;
		end
	endtask

	task automatic test_reset_state();
		check_outputs();
		// no game yet, so this step is dropped.
		step = 1'b1;
		move = make_move(0, 1, 0, 0);
		@(posedge clock);
		#1;
		step = 1'b0;
		move = '0;
		repeat (2) @(posedge clock);
		#1;
		check_outputs();
	endtask

	task automatic test_idle_steps();
		start_game();
		repeat (8) play_step(make_move(0, 0, 0, 0));
	endtask

	task automatic test_player_moves();
		press_to_edge(make_move(0, 0, 1, 0));
		press_to_edge(make_move(1, 0, 0, 0));
		press_to_edge(make_move(0, 1, 0, 0));
		press_to_edge(make_move(0, 0, 0, 1));
		repeat (2) play_step(make_move(1, 1, 0, 0));
		repeat (2) play_step(make_move(0, 0, 1, 1));
		repeat (2) play_step(make_move(1, 1, 1, 1));
	endtask

	task automatic test_random_moves();
		logic [31:0] rnd;
		repeat (20)
		begin
			rnd = $random(seed);
			play_step(rnd[3:0]);
		end
	endtask

	task automatic test_game_over();
		int n;
		if (m_over)
			start_game();
		n = 0;
		while (!m_over && n < 30)
		begin
			do_step(make_move(0, 0, 0, 0));
			n++;
		end
		if (!m_over)
			stop_with_failure("no collision happened within 30 idle steps");
		// board, player and score hold while over.
		step = 1'b1;
		move = make_move(0, 1, 1, 0);
		@(posedge clock);
		#1;
		step = 1'b0;
		move = '0;
		repeat (2) @(posedge clock);
		#1;
		check_outputs();
	endtask

	task automatic test_restart();
		if (!m_over)
			stop_with_failure("restart test entered without a finished game");
		start_game();
		repeat (6) play_step(make_move(0, 0, 0, 0));
	endtask

	initial
	begin
		#(TIMEOUT_NS);
		stop_with_failure("timeout: the tests did not finish in time");
	end

	initial
	begin
		seed = 32'h812d;
		errors = 0;
		reset = 1'b0;
		start = 1'b0;
		step = 1'b0;
		move = '0;
		m_lfsr = `LFSR_SEED;
		m_prev = 15;
		model_clear();
		m_ready = 1'b0;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b1;

		test_reset_state();
		test_idle_steps();
		test_player_moves();
		test_random_moves();
		test_game_over();
		test_restart();

		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/game_pkg.sv
rtl/lane_picker.sv
block_field/block_field.sv
rtl/player_mover.sv
rtl/collision_judge.sv
rtl/game_control.sv
rtl/block_game.sv
bench/block_game_chk.sv
bench/block_game_tb.sv

//--- Makefile
SRCS := $(wildcard common/*.sv common/*.svh rtl/*.sv block_field/*.sv bench/*.sv)
BIN := obj_dir/Vblock_game_tb

.PHONY: all run clean

all: run

$(BIN): $(SRCS) tb.f
	verilator --binary --timing --assert -Wno-fatal --top-module block_game_tb -f tb.f

run: $(BIN)
	./$(BIN) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Some tests failed" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "All tests passed" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
